// ==== source/psram_defines.svh ====
// Widths, timing counts and configuration values for the PSRAM controller
// Timing counts are in clock cycles and must be set for the target clock
// Config values follow the cellular RAM RCR and BCR bit layouts

`ifndef PSRAM_DEFINES_SVH
`define PSRAM_DEFINES_SVH

// ====================
// Widths
// ====================
// RAM word address and data
`define PSRAM_AW 23
`define PSRAM_DW 16
// 16-bit beats per 64-bit CPU transfer
`define PSRAM_BEATS 4
// Words in one video page
`define PSRAM_PAGE_WORDS 16

// ====================
// Timing and config
// ====================
// Power-up wait, short for simulation
`define PSRAM_PUD_CYCLES 40
// Cycles CE stays low per access
`define PSRAM_T_ACC 4
// RCR enables page mode, BCR keeps async operation
`define PSRAM_RCR_VALUE 23'h000090
`define PSRAM_BCR_VALUE 23'h089D1F

`endif

// ==== source/psram_pkg.sv ====
// Shared types for the PSRAM controller
// Word widths come from the defines header

`default_nettype none

`include "psram_defines.svh"

package psram_pkg;

	// One RAM data word and one RAM word address
	typedef logic [`PSRAM_DW-1:0] word_t;
	typedef logic [`PSRAM_AW-1:0] waddr_t;

	// Request opcode from the arbiter
	typedef enum logic [1:0] {
		REQ_CPU_READ   = 2'd0,
		REQ_CPU_WRITE  = 2'd1,
		REQ_VIDEO_READ = 2'd2
	} req_kind_e;

	// Sequencer states
	typedef enum logic [3:0] {
		ST_POWER_UP    = 4'd0,
		ST_RCR_WRITE   = 4'd1,
		ST_RCR_WAIT    = 4'd2,
		ST_BCR_WRITE   = 4'd3,
		ST_BCR_WAIT    = 4'd4,
		ST_IDLE        = 4'd5,
		ST_ACCESS      = 4'd6,
		ST_ACCESS_WAIT = 4'd7,
		ST_RECOVER     = 4'd8
	} seq_state_e;

endpackage

`default_nettype wire

// ==== source/psram_if.sv ====
// Request and response links between arbiter, sequencer and responder
// Request fields hold steady while valid is high and accept is low

`default_nettype none

`include "psram_defines.svh"

// ====================
// Request link
// ====================
interface psram_req_if;
	import psram_pkg::*;

	logic                            valid;
	req_kind_e                       kind;
	waddr_t                          waddr;
	logic [`PSRAM_BEATS*`PSRAM_DW-1:0] wdata;
	// Two byte lanes per beat
	logic [`PSRAM_BEATS*2-1:0]       sel;
	logic                            accept;

	modport arb (output valid, kind, waddr, wdata, sel, input accept);
	modport seq (input valid, kind, waddr, wdata, sel, output accept);
endinterface

// ====================
// Response link
// ====================
// No back-pressure, beat is a one-cycle pulse
interface psram_rsp_if;
	import psram_pkg::*;

	logic      beat;
	req_kind_e kind;
	word_t     rdata;
	logic      first;
	logic      last;

	modport seq (output beat, kind, rdata, first, last);
	modport rsp (input beat, kind, rdata, first, last);
endinterface

`default_nettype wire

// ==== source/psram_arbiter.sv ====
// Picks video over CPU and issues one request at a time
// adr_i is assumed 8-byte aligned, low address bits are dropped

`default_nettype none

`include "psram_defines.svh"

module psram_arbiter (
	input wire                                clk_i,
	input wire                                rst_i,
	input wire                                cyc_i,
	input wire                                stb_i,
	input wire                                we_i,
	input wire [`PSRAM_BEATS*2-1:0]           sel_i,
	input wire [`PSRAM_AW:0]                  adr_i,
	input wire [`PSRAM_BEATS*`PSRAM_DW-1:0]   dat_i,
	input wire                                vcyc_i,
	input wire [`PSRAM_AW:0]                  vadr_i,
	psram_req_if.arb                          req
);
	import psram_pkg::*;

	// Master already served, waiting for its cycle to drop
	logic cpu_busy;
	logic vid_busy;

	logic cpu_req;
	logic vid_req;

	assign cpu_req = cyc_i && stb_i && !cpu_busy;
	assign vid_req = vcyc_i && !vid_busy;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req.valid <= 1'b0;
			cpu_busy <= 1'b0;
			vid_busy <= 1'b0;
		end else begin
			// Release once the master ends its cycle
			if (!vcyc_i)
				vid_busy <= 1'b0;
			if (!(cyc_i && stb_i))
				cpu_busy <= 1'b0;

			if (req.valid && req.accept) begin
				req.valid <= 1'b0;
				if (req.kind == REQ_VIDEO_READ)
					vid_busy <= 1'b1;
				else
					cpu_busy <= 1'b1;
			end else if (!req.valid && (vid_req || cpu_req)) begin
				req.valid <= 1'b1;
			end
		end
	end

	// Request fields, video wins when both ask
	always_ff @(posedge clk_i) begin
		if (!req.valid) begin
			if (vid_req) begin
				req.kind <= REQ_VIDEO_READ;
				req.waddr <= vadr_i[`PSRAM_AW:1];
				req.sel <= '1;
			end else if (cpu_req) begin
				req.kind <= we_i ? REQ_CPU_WRITE : REQ_CPU_READ;
				req.waddr <= adr_i[`PSRAM_AW:1];
				req.wdata <= dat_i;
				req.sel <= sel_i;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/psram_sequencer.sv ====
// Async-mode RAM access timing, power-up wait and RCR/BCR setup
// Each beat holds CE low for PSRAM_T_ACC cycles then one cycle high
// Video reads stop at the end of the 16-word page

`default_nettype none

`include "psram_defines.svh"

module psram_sequencer (
	input wire                  clk_i,
	input wire                  rst_i,
	psram_req_if.seq            req,
	psram_rsp_if.seq            rsp,
	output logic                ram_ce_o,
	output logic                ram_we_o,
	output logic                ram_oe_o,
	output logic                ram_cre_o,
	output logic                ram_ub_o,
	output logic                ram_lb_o,
	output psram_pkg::waddr_t   ram_adr_o,
	output psram_pkg::word_t    ram_dq_o,
	output logic                ram_dq_oe_o,
	input wire psram_pkg::word_t ram_dq_i
);
	import psram_pkg::*;

	localparam int CNT_W = $clog2(`PSRAM_PUD_CYCLES + 1);
	localparam int BI_W  = $clog2(`PSRAM_BEATS);
	localparam int PG_W  = $clog2(`PSRAM_PAGE_WORDS);

	// ====================
	// Control state
	// ====================
	seq_state_e        state;
	logic [CNT_W-1:0]  cnt;
	logic [BI_W-1:0]   beat_idx;
	logic              first_r;
	// Set when the finished beat closed the transfer
	logic              done_r;

	// Latched request
	req_kind_e                          kind_r;
	waddr_t                             addr_r;
	logic [`PSRAM_BEATS*`PSRAM_DW-1:0]  wdata_r;
	logic [`PSRAM_BEATS*2-1:0]          sel_r;

	logic       take;
	logic       is_write;
	logic       cur_last;
	logic [1:0] lanes_n;
	word_t      beat_wdata;

	// Requests only taken once config is done
	assign take = (state == ST_IDLE) && req.valid;
	assign req.accept = take;

	assign is_write = (kind_r == REQ_CPU_WRITE);

	// Video ends at page end, CPU after the fourth beat
	assign cur_last = (kind_r == REQ_VIDEO_READ) ?
		(addr_r[PG_W-1:0] == {PG_W{1'b1}}) :
		(beat_idx == BI_W'(`PSRAM_BEATS - 1));

	// Active-low lanes {ub, lb}, video reads both bytes
	assign lanes_n = (kind_r == REQ_VIDEO_READ) ? 2'b00 : ~sel_r[beat_idx*2 +: 2];

	assign beat_wdata = wdata_r[beat_idx*`PSRAM_DW +: `PSRAM_DW];

	// ====================
	// FSM and pin control
	// ====================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= ST_POWER_UP;
			// Two cycles go to the hand-off into the RCR write
			cnt <= CNT_W'(`PSRAM_PUD_CYCLES - 2);
			beat_idx <= '0;
			first_r <= 1'b0;
			done_r <= 1'b0;
			ram_ce_o <= 1'b1;
			ram_we_o <= 1'b1;
			ram_oe_o <= 1'b1;
			ram_ub_o <= 1'b1;
			ram_lb_o <= 1'b1;
			ram_cre_o <= 1'b0;
			ram_dq_oe_o <= 1'b0;
			rsp.beat <= 1'b0;
		end else begin
			rsp.beat <= 1'b0;
			// Free-running down-counter, loads override below
			if (cnt != '0)
				cnt <= cnt - CNT_W'(1);

			case (state)
			ST_POWER_UP:
				if (cnt == '0)
					state <= ST_RCR_WRITE;

			// Config write, CRE high with address carrying the value
			ST_RCR_WRITE, ST_BCR_WRITE: begin
				ram_cre_o <= 1'b1;
				ram_ce_o <= 1'b0;
				ram_we_o <= 1'b0;
				cnt <= CNT_W'(`PSRAM_T_ACC - 1);
				state <= (state == ST_RCR_WRITE) ? ST_RCR_WAIT : ST_BCR_WAIT;
			end

			ST_RCR_WAIT, ST_BCR_WAIT:
				if (cnt == '0) begin
					ram_cre_o <= 1'b0;
					ram_ce_o <= 1'b1;
					ram_we_o <= 1'b1;
					state <= (state == ST_RCR_WAIT) ? ST_BCR_WRITE : ST_IDLE;
				end

			ST_IDLE:
				if (take) begin
					beat_idx <= '0;
					first_r <= 1'b1;
					state <= ST_ACCESS;
				end

			// Recover doubles as the launch of the next beat
			ST_ACCESS, ST_RECOVER:
				if (state == ST_RECOVER && done_r) begin
					state <= ST_IDLE;
				end else begin
					ram_ce_o <= 1'b0;
					ram_oe_o <= is_write;
					ram_we_o <= !is_write;
					{ram_ub_o, ram_lb_o} <= lanes_n;
					ram_dq_oe_o <= is_write;
					cnt <= CNT_W'(`PSRAM_T_ACC - 1);
					state <= ST_ACCESS_WAIT;
				end

			// End of access, WE rising edge latches write data
			ST_ACCESS_WAIT:
				if (cnt == '0) begin
					ram_ce_o <= 1'b1;
					ram_oe_o <= 1'b1;
					ram_we_o <= 1'b1;
					ram_ub_o <= 1'b1;
					ram_lb_o <= 1'b1;
					ram_dq_oe_o <= 1'b0;
					rsp.beat <= 1'b1;
					done_r <= cur_last;
					first_r <= 1'b0;
					beat_idx <= beat_idx + BI_W'(1);
					state <= ST_RECOVER;
				end

			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// ====================
	// Address and data path
	// ====================
	always_ff @(posedge clk_i) begin
		if (take) begin
			kind_r <= req.kind;
			addr_r <= req.waddr;
			wdata_r <= req.wdata;
			sel_r <= req.sel;
		end

		case (state)
		ST_RCR_WRITE:
			ram_adr_o <= `PSRAM_RCR_VALUE;
		ST_BCR_WRITE:
			ram_adr_o <= `PSRAM_BCR_VALUE;
		ST_ACCESS, ST_RECOVER: begin
			ram_adr_o <= addr_r;
			ram_dq_o <= beat_wdata;
		end
		ST_ACCESS_WAIT:
			if (cnt == '0) begin
				// Read data sampled as OE goes high
				rsp.rdata <= ram_dq_i;
				rsp.kind <= kind_r;
				rsp.first <= first_r;
				rsp.last <= cur_last;
				addr_r <= addr_r + 1'b1;
			end
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/psram_responder.sv ====
// Builds CPU read data and drives ack_o, vack_o and vdat_o
// ack_o and vack_o drop at once when the master ends its cycle

`default_nettype none

`include "psram_defines.svh"

module psram_responder (
	input wire                                 clk_i,
	input wire                                 rst_i,
	psram_rsp_if.rsp                           rsp,
	input wire                                 cyc_i,
	input wire                                 stb_i,
	input wire                                 vcyc_i,
	output logic [`PSRAM_BEATS*`PSRAM_DW-1:0]  dat_o,
	output logic                               ack_o,
	output logic                               vack_o,
	output psram_pkg::word_t                   vdat_o
);
	import psram_pkg::*;

	logic ack_hold;
	logic vack_r;
	logic cpu_beat;
	logic vid_beat;

	assign cpu_beat = rsp.beat && (rsp.kind != REQ_VIDEO_READ);
	assign vid_beat = rsp.beat && (rsp.kind == REQ_VIDEO_READ);

	// ====================
	// Handshake
	// ====================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_hold <= 1'b0;
			vack_r <= 1'b0;
		end else begin
			// One pulse per video word
			vack_r <= vid_beat;
			// Stale ack must not greet the next strobe
			if (!(cyc_i && stb_i))
				ack_hold <= 1'b0;
			if (cpu_beat && rsp.first)
				ack_hold <= 1'b0;
			// Held until the master takes it
			if (cpu_beat && rsp.last)
				ack_hold <= 1'b1;
		end
	end

	assign ack_o = ack_hold && cyc_i && stb_i;
	assign vack_o = vack_r && vcyc_i;

	// ====================
	// Data
	// ====================
	always_ff @(posedge clk_i) begin
		// Lowest address ends up in the low bits
		if (rsp.beat && rsp.kind == REQ_CPU_READ)
			dat_o <= {rsp.rdata, dat_o[`PSRAM_BEATS*`PSRAM_DW-1:`PSRAM_DW]};
		if (vid_beat)
			vdat_o <= rsp.rdata;
	end

endmodule

`default_nettype wire

// ==== source/psram_ctrl.sv ====
// Async PSRAM controller with a 64-bit CPU port and a video page port
// Video has priority, CPU master holds stb_i for the whole transfer
// ram_clk and ram_adv are tied low on the board

`default_nettype none

`include "psram_defines.svh"

module psram_ctrl (
	input wire                                 clk_i,
	input wire                                 rst_i,
	// CPU port
	input wire                                 cyc_i,
	input wire                                 stb_i,
	input wire                                 we_i,
	input wire [`PSRAM_BEATS*2-1:0]            sel_i,
	input wire [`PSRAM_AW:0]                   adr_i,
	input wire [`PSRAM_BEATS*`PSRAM_DW-1:0]    dat_i,
	output logic [`PSRAM_BEATS*`PSRAM_DW-1:0]  dat_o,
	output logic                               ack_o,
	// Video port
	input wire                                 vcyc_i,
	input wire [`PSRAM_AW:0]                   vadr_i,
	output logic                               vack_o,
	output psram_pkg::word_t                   vdat_o,
	// RAM pins, controls active low except CRE
	output logic                               ram_ce_o,
	output logic                               ram_we_o,
	output logic                               ram_oe_o,
	output logic                               ram_cre_o,
	output logic                               ram_ub_o,
	output logic                               ram_lb_o,
	output psram_pkg::waddr_t                  ram_adr_o,
	output psram_pkg::word_t                   ram_dq_o,
	output logic                               ram_dq_oe_o,
	input wire psram_pkg::word_t               ram_dq_i
);

	psram_req_if req_if ();
	psram_rsp_if rsp_if ();

	// Input side
	psram_arbiter arbiter_i (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.sel_i  (sel_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.vcyc_i (vcyc_i),
		.vadr_i (vadr_i),
		.req    (req_if)
	);

	// RAM timing
	psram_sequencer sequencer_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req         (req_if),
		.rsp         (rsp_if),
		.ram_ce_o    (ram_ce_o),
		.ram_we_o    (ram_we_o),
		.ram_oe_o    (ram_oe_o),
		.ram_cre_o   (ram_cre_o),
		.ram_ub_o    (ram_ub_o),
		.ram_lb_o    (ram_lb_o),
		.ram_adr_o   (ram_adr_o),
		.ram_dq_o    (ram_dq_o),
		.ram_dq_oe_o (ram_dq_oe_o),
		.ram_dq_i    (ram_dq_i)
	);

	// Output side
	psram_responder responder_i (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.rsp    (rsp_if),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.vcyc_i (vcyc_i),
		.dat_o  (dat_o),
		.ack_o  (ack_o),
		.vack_o (vack_o),
		.vdat_o (vdat_o)
	);

endmodule

`default_nettype wire

// ==== dv/psram_model.sv ====
// Behavioral async PSRAM, 16-bit words with active-low byte lanes
// Write data is taken just after WE falls and committed on WE rising
// Unwritten words read a fill pattern of their address

`default_nettype none

`include "psram_defines.svh"

module psram_model (
	input wire                    ce_i,
	input wire                    we_i,
	input wire                    oe_i,
	input wire                    cre_i,
	input wire                    ub_i,
	input wire                    lb_i,
	input wire psram_pkg::waddr_t adr_i,
	input wire psram_pkg::word_t  dq_i,
	// Controller drives the data bus when high
	input wire                    dq_oe_i,
	output psram_pkg::word_t      dq_o,
	// Sticky, bus direction did not match the access
	output logic                  dq_fault_o,
	output logic [1:0]            cfg_count_o,
	output psram_pkg::waddr_t     cfg_first_o,
	output psram_pkg::waddr_t     cfg_second_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import psram_pkg::*;

	word_t mem [waddr_t];

	// Write captured during the access
	logic   wr_pend;
	logic   wr_cre;
	logic   wr_ub;
	logic   wr_lb;
	waddr_t wr_adr;
	word_t  wr_dat;
	word_t  old_w;

	function automatic word_t fill_word(input waddr_t a);
		return (a[15:0] ^ {a[22:16], a[22:14]}) ^ 16'hc3a5;
	endfunction

	function automatic word_t read_word(input waddr_t a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	initial begin
		wr_pend = 1'b0;
		dq_fault_o = 1'b0;
		cfg_count_o = 2'd0;
		cfg_first_o = '0;
		cfg_second_o = '0;
	end

	// Sample once address, data and lanes have settled
	always @(negedge we_i) begin
		#1;
		if (!ce_i) begin
			// Array write needs the controller on the data bus
			if (!cre_i && !dq_oe_i)
				dq_fault_o = 1'b1;
			wr_adr = adr_i;
			wr_dat = dq_i;
			wr_cre = cre_i;
			wr_ub = ub_i;
			wr_lb = lb_i;
			wr_pend = 1'b1;
		end
	end

	always @(posedge we_i) begin
		if (wr_pend) begin
			wr_pend = 1'b0;
			if (wr_cre) begin
				// Config register value rides on the address bus
				if (cfg_count_o == 2'd0)
					cfg_first_o = wr_adr;
				else if (cfg_count_o == 2'd1)
					cfg_second_o = wr_adr;
				if (cfg_count_o != 2'd3)
					cfg_count_o = cfg_count_o + 2'd1;
			end else if (!wr_ub || !wr_lb) begin
				old_w = read_word(wr_adr);
				mem[wr_adr] = {wr_ub ? old_w[15:8] : wr_dat[15:8],
					wr_lb ? old_w[7:0] : wr_dat[7:0]};
			end
		end
	end

	// Async read, bus idles at zero
	always @(ce_i or oe_i or adr_i or dq_oe_i) begin
		if (!ce_i && !oe_i) begin
			// Both sides driving the bus
			if (dq_oe_i)
				dq_fault_o = 1'b1;
			dq_o = read_word(adr_i);
		end else begin
			dq_o = '0;
		end
	end

endmodule

`default_nettype wire

// ==== dv/psram_ctrl_properties.sv ====
// Pin and handshake rules on the PSRAM controller
// Rules are checked only out of reset

`default_nettype none

module psram_ctrl_properties (
	input wire clk_i,
	input wire rst_i,
	input wire ram_ce_o,
	input wire ram_we_o,
	input wire ram_oe_o,
	input wire ram_cre_o,
	input wire cyc_i,
	input wire stb_i,
	input wire ack_o,
	input wire vcyc_i,
	input wire vack_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// RAM is never written and read at once
	we_oe_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
		!(!ram_we_o && !ram_oe_o))
		else $error("WE and OE low together");

	// Acknowledges only to an active master
	ack_needs_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> (cyc_i && stb_i))
		else $error("ack_o without cyc_i and stb_i");

	vack_needs_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
		vack_o |-> vcyc_i)
		else $error("vack_o without vcyc_i");

	// Config access is always a write
	cre_is_write: assert property (@(posedge clk_i) disable iff (rst_i)
		ram_cre_o |-> (!ram_we_o && !ram_ce_o))
		else $error("CRE high outside a config write");

endmodule

bind psram_ctrl psram_ctrl_properties props_i (
	.clk_i(clk_i), .rst_i(rst_i), .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o),
	.ram_oe_o(ram_oe_o), .ram_cre_o(ram_cre_o), .cyc_i(cyc_i), .stb_i(stb_i),
	.ack_o(ack_o), .vcyc_i(vcyc_i), .vack_o(vack_o)
);

`default_nettype wire

// ==== dv/psram_ctrl_tb.sv ====
// Directed tests of the PSRAM controller against a behavioral RAM model
// Expected data comes from a reference memory kept by the testbench

`default_nettype none

`include "psram_defines.svh"

module psram_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import psram_pkg::*;

	// Power-up plus about 60 cycles per RAM beat of all tests
	localparam int TOTAL_BEATS = 80;
	localparam int TIMEOUT_CYCLES = `PSRAM_PUD_CYCLES + 60 * TOTAL_BEATS;

	logic clk_i, rst_i, cyc_i, stb_i, we_i, ack_o, vcyc_i, vack_o;
	logic [7:0] sel_i;
	logic [23:0] adr_i, vadr_i;
	logic [63:0] dat_i, dat_o;
	word_t vdat_o, ram_dq_o, ram_dq_i;
	waddr_t ram_adr_o, cfg_first, cfg_second;
	logic ram_ce_o, ram_we_o, ram_oe_o, ram_cre_o, ram_ub_o, ram_lb_o, ram_dq_oe_o;
	logic [1:0] cfg_count;
	logic dq_fault;

	string cur_test;
	int checks, errors, test_errors, tests_run, tests_failed, cycles;
	word_t ref_mem [waddr_t];
	waddr_t cpu_addr, page_base;

	psram_ctrl psram_ctrl_i (.*);

	psram_model model_i (
		.ce_i(ram_ce_o), .we_i(ram_we_o), .oe_i(ram_oe_o), .cre_i(ram_cre_o),
		.ub_i(ram_ub_o), .lb_i(ram_lb_o), .adr_i(ram_adr_o), .dq_i(ram_dq_o),
		.dq_oe_i(ram_dq_oe_o), .dq_o(ram_dq_i), .dq_fault_o(dq_fault),
		.cfg_count_o(cfg_count), .cfg_first_o(cfg_first),
		.cfg_second_o(cfg_second)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout after %0d cycles, test %s hung", cycles, cur_test);
		$display("CHECKS FAILED");
		$finish;
	end

	// ====================
	// Helpers
	// ====================
	task automatic check_value(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			test_errors++;
			$display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	// Failure that is not a value mismatch
	task automatic note_problem(input string msg);
		errors++;
		test_errors++;
		$display("%s: %s", cur_test, msg);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		// Data bus direction has to follow the access type
		check_value("data bus direction fault", 0, dq_fault);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("%s: %0d error(s)", cur_test, test_errors);
		end else begin
			$display("%s: ok", cur_test);
		end
	endtask

	// Reference memory update, honoring byte selects
	task automatic store_expected(input waddr_t wa, input logic [63:0] d,
		input logic [7:0] sel);
		int b;
		int l;
		for (b = 0; b < 4; b++)
			for (l = 0; l < 2; l++)
				if (sel[b*2+l])
					ref_mem[waddr_t'(wa + b)][l*8 +: 8] = d[b*16+l*8 +: 8];
	endtask

	function automatic logic [63:0] expected_qword(input waddr_t wa);
		logic [63:0] r;
		int b;
		for (b = 0; b < 4; b++)
			r[b*16 +: 16] = ref_mem[waddr_t'(wa + b)];
		return r;
	endfunction

	// One CPU transfer, stb_i held until ack_o
	task automatic cpu_xfer(input logic we, input logic [7:0] sel, input waddr_t wa,
		input logic [63:0] wdat, output logic [63:0] rdat);
		int waited;
		@(negedge clk_i);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = we;
		sel_i = sel;
		adr_i = {wa, 1'b0};
		dat_i = wdat;
		waited = 0;
		@(negedge clk_i);
		while (!ack_o) begin
			@(negedge clk_i);
			waited++;
		end
		rdat = dat_o;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		// Four beats with their recover cycles come before the ack
		checks++;
		if (waited < `PSRAM_BEATS * (`PSRAM_T_ACC + 1))
			note_problem($sformatf("ack_o came after %0d cycles, before four beats",
				waited));
	endtask

	task automatic video_read(input waddr_t start);
		int expected;
		int got;
		waddr_t a;
		expected = `PSRAM_PAGE_WORDS - int'(start[3:0]);
		got = 0;
		a = start;
		@(negedge clk_i);
		vcyc_i = 1'b1;
		vadr_i = {start, 1'b0};
		while (got < expected) begin
			@(negedge clk_i);
			if (vack_o) begin
				check_value("video word", ref_mem[a], vdat_o);
				a++;
				got++;
			end
		end
		// No pulse past the page end
		repeat (3 * (`PSRAM_T_ACC + 1)) begin
			@(negedge clk_i);
			if (vack_o)
				got++;
		end
		check_value("video word count", expected, got);
		vcyc_i = 1'b0;
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_config();
		start_test("config");
		while (cfg_count < 2'd2)
			@(negedge clk_i);
		check_value("RCR value", `PSRAM_RCR_VALUE, cfg_first);
		check_value("BCR value", `PSRAM_BCR_VALUE, cfg_second);
		finish_test();
	endtask

	task automatic test_cpu_rw();
		logic [63:0] d;
		logic [63:0] rd;
		start_test("cpu_write_read");
		cpu_addr = waddr_t'($urandom) & ~waddr_t'(3);
		d = {$urandom, $urandom};
		cpu_xfer(1'b1, 8'hff, cpu_addr, d, rd);
		store_expected(cpu_addr, d, 8'hff);
		cpu_xfer(1'b0, 8'hff, cpu_addr, '0, rd);
		check_value("read data", d, rd);
		finish_test();
	endtask

	task automatic test_byte_lanes();
		logic [63:0] d;
		logic [63:0] rd;
		logic [7:0] sel;
		waddr_t wa;
		start_test("byte_lanes");
		wa = waddr_t'($urandom) & ~waddr_t'(3);
		d = {$urandom, $urandom};
		cpu_xfer(1'b1, 8'hff, wa, d, rd);
		store_expected(wa, d, 8'hff);
		d = {$urandom, $urandom};
		sel = 8'($urandom);
		cpu_xfer(1'b1, sel, wa, d, rd);
		store_expected(wa, d, sel);
		cpu_xfer(1'b0, 8'hff, wa, '0, rd);
		check_value("masked readback", expected_qword(wa), rd);
		finish_test();
	endtask

	task automatic test_video_page();
		logic [63:0] d;
		logic [63:0] rd;
		int i;
		start_test("video_page");
		page_base = waddr_t'($urandom) & ~waddr_t'(15);
		for (i = 0; i < 4; i++) begin
			d = {$urandom, $urandom};
			cpu_xfer(1'b1, 8'hff, waddr_t'(page_base + 4 * i), d, rd);
			store_expected(waddr_t'(page_base + 4 * i), d, 8'hff);
		end
		// Start mid-page
		video_read(waddr_t'(page_base + 1 + $urandom % 15));
		finish_test();
	endtask

	task automatic test_video_priority();
		int got;
		int at_ack;
		logic acked;
		waddr_t a;
		start_test("video_priority");
		got = 0;
		at_ack = -1;
		acked = 1'b0;
		a = page_base;
		@(negedge clk_i);
		vcyc_i = 1'b1;
		vadr_i = {page_base, 1'b0};
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = 1'b0;
		sel_i = 8'hff;
		adr_i = {cpu_addr, 1'b0};
		while (got < `PSRAM_PAGE_WORDS || !acked) begin
			@(negedge clk_i);
			if (vack_o) begin
				check_value("video word", ref_mem[a], vdat_o);
				a++;
				got++;
			end
			if (ack_o && !acked) begin
				acked = 1'b1;
				at_ack = got;
				check_value("CPU read data", expected_qword(cpu_addr), dat_o);
				cyc_i = 1'b0;
				stb_i = 1'b0;
			end
		end
		check_value("video words before ack", `PSRAM_PAGE_WORDS, at_ack);
		vcyc_i = 1'b0;
		finish_test();
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(32'h8b47));
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		vcyc_i = 1'b0;
		vadr_i = '0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = "reset";
		repeat (4) @(negedge clk_i);
		rst_i = 1'b0;

		test_config();
		test_cpu_rw();
		test_byte_lanes();
		test_video_page();
		test_video_priority();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/psram_pkg.sv
source/psram_if.sv
source/psram_arbiter.sv
source/psram_sequencer.sv
source/psram_responder.sv
source/psram_ctrl.sv
dv/psram_model.sv
dv/psram_ctrl_properties.sv
dv/psram_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PSRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module psram_ctrl_tb -Mdir obj_dir

out=$(./obj_dir/Vpsram_ctrl_tb || true)
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED"
